// ==== ql_activity_led.sv ====
/*
 * SD activity indicator.
 * Any toggle on the SD data lines restarts a hold counter; the light
 * stays on until the counter reaches the hold length.
 */
`timescale 1ns/10ps
`default_nettype none

module ql_activity_led #(
	parameter logic [31:0] ACT_HOLD = 32'd4000000
) (
	input  wire clk_sys,
	input  wire reset,
	input  wire sd_mosi,
	input  wire sd_miso,
	output wire sd_active
);

	logic        old_mosi;
	logic        old_miso;
	logic        toggled;
	logic [31:0] hold_cnt;

	// Previous line levels for edge detection
	always_ff @(posedge clk_sys) begin
		old_mosi <= sd_mosi;
		old_miso <= sd_miso;
	end

	assign toggled = (old_mosi ^ sd_mosi) | (old_miso ^ sd_miso);

	// Saturates at the hold length
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_cnt <= 32'd0;
		end else if (toggled) begin
			hold_cnt <= 32'd0;
		end else if (hold_cnt < ACT_HOLD) begin
			hold_cnt <= hold_cnt + 32'd1;
		end
	end

	assign sd_active = (hold_cnt < ACT_HOLD);

endmodule

`default_nettype wire

// ==== ql_bus_decode.sv ====
/*
 * CPU bus decoder for the 68008 memory map.
 * Produces region selects and the read-data mux combinationally, and
 * holds the RAM size latch, video-mode register and CPU clock enable.
 */
`timescale 1ns/10ps
`default_nettype none

module ql_bus_decode (
	input  wire                    clk_sys,
	input  wire                    sys_reset,
	input  wire [1:0]              ram_size,
	input  wire ql_pkg::ce_t       ce,
	input  wire ql_pkg::cpu_bus_t  bus,
	input  wire ql_pkg::read_src_t rd_src,
	output ql_pkg::sel_t           sel,
	output logic [15:0]            cpu_din,
	output logic [7:0]             mc_stat,
	output logic                   cpu_clkena
);

	logic [1:0]  ram_cfg;
	logic        cpu_enable;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        cpu_idle;
	logic        cpu_act;
	logic        in_rom;
	logic        in_io;
	logic        in_bram;
	logic        in_xram;
	logic        in_ram;
	logic [15:0] io_dout;

	// ========================================
	// Bus cycle type
	// ========================================

	assign cpu_rd   = (bus.busstate == ql_pkg::BUS_FETCH) || (bus.busstate == ql_pkg::BUS_READ);
	assign cpu_wr   = (bus.busstate == ql_pkg::BUS_WRITE) && !bus.rw;
	assign cpu_idle = (bus.busstate == ql_pkg::BUS_IDLE);
	assign cpu_act  = cpu_rd || cpu_wr;

	// ========================================
	// Region decode
	// ========================================

	assign in_rom  = cpu_act && (bus.addr[19:16] == 4'h0);
	assign in_io   = cpu_act && (bus.addr[19:14] == ql_pkg::IO_BASE_PAGE);
	assign in_bram = cpu_act && (bus.addr[19:17] == ql_pkg::RAM_BASE_BLOCK);

	// 512k fills the two mixed windows, 768k adds the top one
	assign in_xram = cpu_act && (((|ram_cfg) && (^bus.addr[19:18]))
		|| (ram_cfg[1] && (&bus.addr[19:18])));
	assign in_ram  = in_bram || in_xram;

	always_comb begin
		sel.rom_sel   = in_rom;
		sel.qlsd_rd   = in_rom && (bus.addr[15:0] == ql_pkg::QLSD_REG_ADDR);
		sel.ram_oe    = ce.cpu_cycle && cpu_rd && in_ram;
		sel.ram_we    = ce.cpu_cycle && cpu_wr && in_ram;
		sel.vram_we   = sel.ram_we && (bus.addr[19:16] == ql_pkg::VRAM_BANK);
		sel.io_sel    = in_io;
		sel.pc_sel    = ce.cpu_cycle && in_io && !bus.addr[6];
		sel.mouse_sel = in_io && (bus.addr[13:8] == 6'h3f);
		// Single write-only video register, low byte only
		sel.vmode_wr  = ce.cpu_cycle && in_io && bus.addr[6] && bus.addr[5]
			&& bus.addr[1] && cpu_wr && !bus.ds[0];
	end

	// ========================================
	// Read data
	// ========================================

	always_comb begin
		if (sel.mouse_sel) begin
			io_dout = {rd_src.mouse_dout, rd_src.mouse_dout};
		end else if (!bus.addr[6]) begin
			io_dout = rd_src.pc_dout;
		end else begin
			io_dout = 16'h0000;
		end
	end

	// SD register sits inside the ROM window and wins over it
	always_comb begin
		if (sel.qlsd_rd) begin
			cpu_din = {rd_src.qlsd_dout, rd_src.qlsd_dout};
		end else if (in_rom) begin
			cpu_din = rd_src.rom_dout;
		end else if (in_ram) begin
			cpu_din = rd_src.ram_dout;
		end else if (in_io) begin
			cpu_din = io_dout;
		end else begin
			cpu_din = ql_pkg::OPEN_BUS_DATA;
		end
	end

	// ========================================
	// Registers
	// ========================================

	// Size only changes while the system is held in reset
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ram_cfg <= ram_size;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			mc_stat <= 8'h00;
		end else if (ce.ce_bus_p && sel.vmode_wr) begin
			mc_stat <= bus.dout[7:0];
		end
	end

	// CPU may advance on its own cycle or when not touching the bus
	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			cpu_enable <= 1'b0;
		end else if (ce.ce_bus_n) begin
			cpu_enable <= ce.cpu_cycle || cpu_idle;
		end
	end

	assign cpu_clkena = cpu_enable & ce.ce_bus_p;

endmodule

`default_nettype wire

// ==== ql_clock_enables.sv ====
/*
 * Clock-enable generator for the system clock domain.
 * A 5-bit divider gives bus, video and SD strobes; a separate divider
 * gives the 131 kHz tick. The CPU duty cycle follows the speed setting.
 */
`timescale 1ns/10ps
`default_nettype none

module ql_clock_enables (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire ql_pkg::cpu_speed_e cpu_speed,
	output ql_pkg::ce_t        ce
);

	logic [4:0] div;
	logic [9:0] div_131k;
	logic       ce_p;
	logic       ce_n;
	logic       ce_sd_r;
	logic       ce_131k_r;
	logic       duty;
	logic       sub_cycle;

	// ========================================
	// Dividers and raw strobes
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div       <= 5'd0;
			div_131k  <= 10'd0;
			ce_p      <= 1'b0;
			ce_n      <= 1'b0;
			ce_sd_r   <= 1'b0;
			ce_131k_r <= 1'b0;
		end else begin
			div <= div + 5'd1;

			if (div_131k == ql_pkg::DIV_131K_WRAP) begin
				div_131k <= 10'd0;
			end else begin
				div_131k <= div_131k + 10'd1;
			end
			ce_131k_r <= (div_131k == 10'd0);

			// Bus phases 4 cycles apart
			ce_p    <= (div[2:0] == 3'd0);
			ce_n    <= (div[2:0] == 3'd4);
			ce_sd_r <= (div[1:0] == 2'd0);
		end
	end

	// ========================================
	// Speed-dependent CPU duty
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			duty      <= 1'b0;
			sub_cycle <= 1'b0;
		end else if (div[2:0] == 3'd0) begin
			case (cpu_speed)
				ql_pkg::SPEED_NORMAL: duty <= (div[4:3] == 2'd0);
				ql_pkg::SPEED_X2:     duty <= ~div[3];
				default:              duty <= 1'b1;
			endcase

			// Normal speed uses every other duty window
			if (cpu_speed == ql_pkg::SPEED_NORMAL) begin
				if (div[4:3] == 2'd0) begin
					sub_cycle <= ~sub_cycle;
				end
			end else begin
				sub_cycle <= 1'b1;
			end
		end
	end

	always_comb begin
		ce.ce_bus_p  = ce_p & duty;
		ce.ce_bus_n  = ce_n & duty;
		ce.cpu_cycle = duty & sub_cycle;
		ce.ce_vid    = ce_p;
		ce.ce_sd     = ce_sd_r;
		ce.ce_131k   = ce_131k_r;
	end

endmodule

`default_nettype wire

// ==== ql_glue_top.sv ====
/*
 * System glue top level for the 68008 home-computer core.
 * Ties together clock enables, reset stretching, bus decoding and the
 * SD activity light, and forms the user light.
 */
`timescale 1ns/10ps
`default_nettype none

module ql_glue_top #(
	parameter logic [11:0] RESET_HOLD = 12'd4095,
	parameter logic [31:0] ACT_HOLD   = 32'd4000000
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     reset_req,
	input  wire                     download_active,
	input  wire ql_pkg::cpu_speed_e cpu_speed,
	input  wire [1:0]               ram_size,
	input  wire ql_pkg::cpu_bus_t   bus,
	input  wire ql_pkg::read_src_t  rd_src,
	input  wire                     sd_mosi,
	input  wire                     sd_miso,
	input  wire                     mdv_led,
	output ql_pkg::ce_t             ce,
	output wire                     sys_reset,
	output ql_pkg::sel_t            sel,
	output wire [15:0]              cpu_din,
	output wire [7:0]               mc_stat,
	output wire                     cpu_clkena,
	output wire                     led_user
);

	logic sd_active;

	// ========================================
	// Clocking and reset
	// ========================================

	// Strobes run from the external reset so the stretcher can count
	ql_clock_enables u_clock_enables (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_speed (cpu_speed),
		.ce        (ce)
	);

	ql_reset_stretch #(
		.RESET_HOLD (RESET_HOLD)
	) u_reset_stretch (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.reset_req       (reset_req),
		.download_active (download_active),
		.ce_bus_p        (ce.ce_bus_p),
		.sys_reset       (sys_reset)
	);

	// ========================================
	// Bus and indicators
	// ========================================

	ql_bus_decode u_bus_decode (
		.clk_sys    (clk_sys),
		.sys_reset  (sys_reset),
		.ram_size   (ram_size),
		.ce         (ce),
		.bus        (bus),
		.rd_src     (rd_src),
		.sel        (sel),
		.cpu_din    (cpu_din),
		.mc_stat    (mc_stat),
		.cpu_clkena (cpu_clkena)
	);

	ql_activity_led #(
		.ACT_HOLD (ACT_HOLD)
	) u_activity_led (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sd_mosi   (sd_mosi),
		.sd_miso   (sd_miso),
		.sd_active (sd_active)
	);

	// Microdrive and download also light it
	assign led_user = sd_active | mdv_led | download_active;

endmodule

`default_nettype wire

// ==== ql_pkg.sv ====
/*
 * Shared types and constants for the 68008 system glue.
 * Bus, strobe, select and read-source bundles used by every block
 * and by the testbench, plus the memory map constants.
 */
`default_nettype none

package ql_pkg;

	// ========================================
	// CPU bus
	// ========================================

	typedef struct packed {
		logic [19:0] addr;
		logic [1:0]  ds;        // Active low, upper then lower
		logic [15:0] dout;
		logic [1:0]  busstate;
		logic        rw;        // Low for write
	} cpu_bus_t;

	// Bus states as reported by the CPU core
	localparam logic [1:0] BUS_FETCH = 2'd0;
	localparam logic [1:0] BUS_IDLE  = 2'd1;
	localparam logic [1:0] BUS_READ  = 2'd2;
	localparam logic [1:0] BUS_WRITE = 2'd3;

	// ========================================
	// Clock enables and speed
	// ========================================

	typedef struct packed {
		logic ce_bus_p;
		logic ce_bus_n;
		logic cpu_cycle;
		logic ce_vid;
		logic ce_sd;
		logic ce_131k;
	} ce_t;

	// Fourth code behaves as x4
	typedef enum logic [1:0] {
		SPEED_NORMAL = 2'd0,
		SPEED_X2     = 2'd1,
		SPEED_X4     = 2'd2,
		SPEED_X4_ALT = 2'd3
	} cpu_speed_e;

	// Tick divider runs 0..640
	localparam logic [9:0] DIV_131K_WRAP = 10'd640;

	// ========================================
	// Selects and read sources
	// ========================================

	typedef struct packed {
		logic rom_sel;
		logic qlsd_rd;
		logic ram_oe;
		logic ram_we;
		logic vram_we;
		logic io_sel;
		logic pc_sel;
		logic mouse_sel;
		logic vmode_wr;
	} sel_t;

	typedef struct packed {
		logic [15:0] rom_dout;
		logic [15:0] ram_dout;
		logic [15:0] pc_dout;
		logic [7:0]  qlsd_dout;
		logic [7:0]  mouse_dout;
	} read_src_t;

	// Memory map
	localparam logic [15:0] QLSD_REG_ADDR  = 16'hfee4;  // Only readable SD register
	localparam logic [5:0]  IO_BASE_PAGE   = 6'd6;      // I/O area from 18000
	localparam logic [2:0]  RAM_BASE_BLOCK = 3'd1;      // 128k at 20000
	localparam logic [3:0]  VRAM_BANK      = 4'd2;
	localparam logic [15:0] OPEN_BUS_DATA  = 16'hffff;

endpackage

`default_nettype wire

// ==== ql_reset_stretch.sv ====
/*
 * System reset stretcher.
 * Any reset cause reloads a down counter that then steps once per
 * bus strobe; system reset stays high until it reaches zero.
 */
`timescale 1ns/10ps
`default_nettype none

module ql_reset_stretch #(
	parameter logic [11:0] RESET_HOLD = 12'd4095
) (
	input  wire clk_sys,
	input  wire reset,
	input  wire reset_req,
	input  wire download_active,
	input  wire ce_bus_p,
	output wire sys_reset
);

	logic [11:0] hold_cnt;
	logic        any_cause;

	// ROM download keeps the system quiet as well
	assign any_cause = reset | reset_req | download_active;

	always_ff @(posedge clk_sys) begin
		if (any_cause) begin
			hold_cnt <= RESET_HOLD;
		end else if (ce_bus_p && hold_cnt != 12'd0) begin
			hold_cnt <= hold_cnt - 12'd1;
		end
	end

	assign sys_reset = (hold_cnt != 12'd0);

endmodule

`default_nettype wire

// ==== tb.f ====
ql_pkg.sv
ql_clock_enables.sv
ql_reset_stretch.sv
ql_bus_decode.sv
ql_activity_led.sv
ql_glue_top.sv
tb_ql_glue.sv

// ==== tb_ql_glue.sv ====
/*
 * Testbench for the 68008 system glue top level.
 * Drives random bus cycles and SD toggles from an LCG and checks
 * strobes, reset stretching, decode, video mode and the user light.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_ql_glue;

	logic               clk_sys;
	logic               reset;
	logic               reset_req;
	logic               download_active;
	ql_pkg::cpu_speed_e cpu_speed;
	logic [1:0]         ram_size;
	ql_pkg::cpu_bus_t   bus;
	ql_pkg::read_src_t  rd_src;
	logic               sd_mosi;
	logic               sd_miso;
	logic               mdv_led;
	ql_pkg::ce_t        ce;
	logic               sys_reset;
	ql_pkg::sel_t       sel;
	logic [15:0]        cpu_din;
	logic [7:0]         mc_stat;
	logic               cpu_clkena;
	logic               led_user;

	logic [31:0] seed;
	int          cycle = 0;
	int          vid_last = -1;
	int          sd_last = -1;
	int          tick_last = -1;
	logic [3:0]  bus_p_hist = 4'd0;
	logic        en_model = 1'b0;

	ql_glue_top #(
		.RESET_HOLD (12'd20),
		.ACT_HOLD   (32'd50)
	) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		$display("FAIL %s expected %h got %h", name, expected, got);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// Reference decode from the memory map with cpu_cycle held high at x4
	task automatic predict_decode(input ql_pkg::cpu_bus_t b, input ql_pkg::read_src_t s,
		input logic [1:0] cfg, output ql_pkg::sel_t es, output logic [15:0] ed);
		logic rd;
		logic wr;
		logic act;
		logic xwin;
		logic ram;
		rd  = (b.busstate == 2'd0) || (b.busstate == 2'd2);
		wr  = (b.busstate == 2'd3) && !b.rw;
		act = rd || wr;
		if (b.addr >= 20'h40000 && b.addr < 20'hc0000) begin
			xwin = (cfg != 2'b00);
		end else begin
			xwin = (b.addr >= 20'hc0000) && cfg[1];
		end
		ram = act && ((b.addr >= 20'h20000 && b.addr < 20'h40000) || xwin);
		es.rom_sel   = act && (b.addr < 20'h10000);
		es.qlsd_rd   = es.rom_sel && (b.addr[15:0] == 16'hfee4);
		es.ram_oe    = rd && ram;
		es.ram_we    = wr && ram;
		es.vram_we   = es.ram_we && (b.addr >= 20'h20000) && (b.addr < 20'h30000);
		es.io_sel    = act && (b.addr >= 20'h18000) && (b.addr <= 20'h1bfff);
		es.pc_sel    = es.io_sel && !b.addr[6];
		es.mouse_sel = es.io_sel && (b.addr[13:8] == 6'h3f);
		es.vmode_wr  = es.io_sel && wr && b.addr[6] && b.addr[5] && b.addr[1] && !b.ds[0];
		ed = 16'hffff;
		if (es.qlsd_rd) begin
			ed = {2{s.qlsd_dout}};
		end else if (es.rom_sel) begin
			ed = s.rom_dout;
		end else if (ram) begin
			ed = s.ram_dout;
		end else if (es.io_sel) begin
			if (es.mouse_sel) begin
				ed = {2{s.mouse_dout}};
			end else if (!b.addr[6]) begin
				ed = s.pc_dout;
			end else begin
				ed = 16'h0000;
			end
		end
	endtask

	// ========================================
	// Test phases
	// ========================================

	task automatic check_speed(input ql_pkg::cpu_speed_e spd, input int per_window);
		int hits;
		hits = 0;
		next_cycle();
		cpu_speed = spd;
		repeat (128) @(negedge clk_sys);
		while (cycle % 64 != 0) @(negedge clk_sys);
		repeat (64) begin
			@(negedge clk_sys);
			if (ce.ce_bus_p && ce.cpu_cycle) hits++;
		end
		assert (hits == per_window) else report_mismatch("cpu_cycle count", per_window, hits);
	endtask

	// Stretch must end right after the 20th bus strobe past release
	task automatic check_stretch();
		int pulses;
		pulses = 0;
		next_cycle();
		reset_req = 1'b1;
		next_cycle();
		reset_req = 1'b0;
		repeat (200) begin
			@(negedge clk_sys);
			assert (sys_reset == (pulses < 20))
				else report_mismatch("sys_reset", 32'(pulses < 20), 32'(sys_reset));
			if (ce.ce_bus_p) pulses++;
		end
	endtask

	task automatic run_decode(input int n, input logic [1:0] cfg);
		logic [31:0]  r;
		logic [63:0]  wide;
		ql_pkg::sel_t es;
		logic [15:0]  ed;
		repeat (n) begin
			next_cycle();
			r = lcg_next();
			case (r[2:0])
				3'd0:    bus.addr = {4'h0, r[31:16]};
				3'd1:    bus.addr = 20'h0fee4;
				3'd2:    bus.addr = {6'd6, r[29:16]};
				3'd3:    bus.addr = {12'h1bf, r[23:16]};
				3'd4:    bus.addr = {6'd6, r[29:23], 2'b11, r[22:20], 1'b1, r[19]};
				default: bus.addr = r[31:12];
			endcase
			r = lcg_next();
			bus.busstate = r[1:0];
			bus.rw       = r[2];
			bus.ds       = r[4:3];
			bus.dout     = r[31:16];
			wide         = {lcg_next(), lcg_next()};
			rd_src       = wide[55:0];
			@(negedge clk_sys);
			predict_decode(bus, rd_src, cfg, es, ed);
			assert (ce.cpu_cycle) else report_mismatch("cpu_cycle", 32'd1, 32'(ce.cpu_cycle));
			assert (sel == es) else report_mismatch("sel", 32'(es), 32'(sel));
			assert (cpu_din == ed) else report_mismatch("cpu_din", 32'(ed), 32'(cpu_din));
		end
	endtask

	task automatic write_vmode(input logic [7:0] val, input logic lower_on,
		input logic [7:0] expect_after);
		next_cycle();
		bus.addr     = 20'h18062;
		bus.busstate = 2'd3;
		bus.rw       = 1'b0;
		bus.ds       = {1'b1, !lower_on};
		bus.dout     = {8'h5a, val};
		do @(negedge clk_sys); while (!ce.ce_bus_p);
		@(negedge clk_sys);
		assert (mc_stat == expect_after)
			else report_mismatch("mc_stat", 32'(expect_after), 32'(mc_stat));
		next_cycle();
		bus.busstate = 2'd1;
		bus.rw       = 1'b1;
	endtask

	// Light is on for cycles 1 to 50 after a toggle drive
	task automatic check_activity();
		int          since;
		logic [31:0] r;
		logic        expect_on;
		since = 1000;
		for (int i = 0; i < 160; i++) begin
			@(posedge clk_sys);
			since = since + 1;
			#2;
			expect_on = (since >= 1) && (since <= 50);
			r = lcg_next();
			if (i < 80 && r[3:0] < 4'd3) begin
				if (r[4]) begin
					sd_mosi = ~sd_mosi;
				end else begin
					sd_miso = ~sd_miso;
				end
				since = 0;
			end
			@(negedge clk_sys);
			assert (led_user == expect_on)
				else report_mismatch("led_user", 32'(expect_on), 32'(led_user));
		end
	endtask

	// ========================================
	// Monitors
	// ========================================

	always @(posedge clk_sys) begin
		cycle = cycle + 1;
		if (cycle > 6000) begin
			$display("Timeout: the run did not finish within 6000 cycles");
			$display("Test FAILED");
			$fatal(1);
		end
	end

	always @(negedge clk_sys) begin
		if (reset) begin
			bus_p_hist = 4'd0;
			en_model   = 1'b0;
		end else begin
			if (ce.ce_vid) begin
				if (vid_last >= 0) begin
					assert (cycle - vid_last == 8)
						else report_mismatch("ce_vid spacing", 8, cycle - vid_last);
				end
				assert (ce.ce_sd) else report_mismatch("ce_sd", 32'd1, 32'(ce.ce_sd));
				vid_last = cycle;
			end
			if (ce.ce_sd) begin
				if (sd_last >= 0) begin
					assert (cycle - sd_last == 4)
						else report_mismatch("ce_sd spacing", 4, cycle - sd_last);
				end
				sd_last = cycle;
			end
			if (ce.ce_131k) begin
				if (tick_last >= 0) begin
					assert (cycle - tick_last == 641)
						else report_mismatch("ce_131k spacing", 641, cycle - tick_last);
				end
				tick_last = cycle;
			end

			// Falling bus phase trails the rising one by four cycles
			assert (ce.ce_bus_n == bus_p_hist[3])
				else report_mismatch("ce_bus_n", 32'(bus_p_hist[3]), 32'(ce.ce_bus_n));
			bus_p_hist = {bus_p_hist[2:0], ce.ce_bus_p};

			// CPU enable picked up on the falling phase, used on the rising one
			assert (cpu_clkena == (en_model && ce.ce_bus_p))
				else report_mismatch("cpu_clkena", 32'(en_model && ce.ce_bus_p),
					32'(cpu_clkena));
			if (sys_reset) begin
				en_model = 1'b0;
			end else if (ce.ce_bus_n) begin
				en_model = ce.cpu_cycle || (bus.busstate == 2'd1);
			end
		end
	end

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		logic [31:0] r;
		seed            = 32'hf174fbad;
		reset           = 1'b1;
		reset_req       = 1'b0;
		download_active = 1'b0;
		cpu_speed       = ql_pkg::SPEED_X4;
		ram_size        = 2'b01;
		bus             = '0;
		// Pending read so the CPU enable follows cpu_cycle at normal speed
		bus.busstate    = 2'd2;
		bus.rw          = 1'b1;
		bus.ds          = 2'b11;
		rd_src          = '0;
		sd_mosi         = 1'b0;
		sd_miso         = 1'b0;
		mdv_led         = 1'b0;
		repeat (16) next_cycle();
		assert (ce == 6'd0) else report_mismatch("ce", 32'd0, 32'(ce));
		assert (!cpu_clkena) else report_mismatch("cpu_clkena", 32'd0, 32'(cpu_clkena));
		assert (mc_stat == 8'h00) else report_mismatch("mc_stat", 32'd0, 32'(mc_stat));
		reset = 1'b0;
		while (sys_reset) @(negedge clk_sys);

		check_speed(ql_pkg::SPEED_NORMAL, 1);
		check_speed(ql_pkg::SPEED_X2, 4);
		check_speed(ql_pkg::SPEED_X4_ALT, 8);
		check_speed(ql_pkg::SPEED_X4, 8);

		// Size change after release waits for the next reset
		check_stretch();
		next_cycle();
		ram_size = 2'b10;
		run_decode(200, 2'b01);
		check_stretch();
		next_cycle();
		ram_size = 2'b00;
		run_decode(150, 2'b10);

		r = lcg_next();
		write_vmode(r[7:0], 1'b1, r[7:0]);
		write_vmode(~r[7:0], 1'b0, r[7:0]);

		check_activity();
		next_cycle();
		mdv_led = 1'b1;
		@(negedge clk_sys);
		assert (led_user) else report_mismatch("led_user", 32'd1, 32'(led_user));
		next_cycle();
		mdv_led         = 1'b0;
		download_active = 1'b1;
		@(negedge clk_sys);
		assert (led_user) else report_mismatch("led_user", 32'd1, 32'(led_user));
		next_cycle();
		download_active = 1'b0;
		@(negedge clk_sys);
		assert (!led_user) else report_mismatch("led_user", 32'd0, 32'(led_user));

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
